//--- src/lsu_pkg.sv
// Load/store unit package with opcode and FSM state enums, AXI attributes, opcode helpers
package lsu_pkg;

   // Access opcodes of the execute stage
   typedef enum logic [3:0] {
      LB  = 4'd0,
      LH  = 4'd1,
      LW  = 4'd2,
      LD  = 4'd3,
      LBU = 4'd4,
      LHU = 4'd5,
      LWU = 4'd6,
      SB  = 4'd7,
      SH  = 4'd8,
      SW  = 4'd9,
      SD  = 4'd10
   } lsu_op_e;

   // Uncached access FSM states
   typedef enum logic [1:0] {
      UNC_IDLE   = 2'd0,
      UNC_WAIT_B = 2'd1,
      UNC_WAIT_R = 2'd2,
      UNC_OUT    = 2'd3
   } unc_state_e;

   // AXI attributes driven on every uncached request
   localparam logic [1:0] AXI_BURST_INCR           = 2'b01;
   localparam logic [3:0] AXI_CACHE_NC_NB          = 4'b0010;
   localparam logic [2:0] AXI_PROT_DATA_SEC_UNPRIV = 3'b000;
   localparam logic [1:0] AXI_RESP_OKAY            = 2'b00;

   function automatic logic op_is_store(lsu_op_e op);
      return op inside {SB, SH, SW, SD};
   endfunction

   // log2 of the access bytes, as used for AxSIZE
   function automatic logic [2:0] op_size(lsu_op_e op);
      logic [2:0] size;
      case (op)
         LB, LBU, SB: size = 3'd0;
         LH, LHU, SH: size = 3'd1;
         LW, LWU, SW: size = 3'd2;
         default:     size = 3'd3;
      endcase
      return size;
   endfunction

   function automatic logic op_is_signed(lsu_op_e op);
      return op inside {LB, LH, LW};
   endfunction

endpackage

//--- src/lsu_store_align.sv
// Store aligner placing store data on its byte lanes and building the byte mask
`timescale 1ns/1ps

module lsu_store_align #(
   parameter int CONFIG_DW = 64
) (
   input  lsu_pkg::lsu_op_e        op,
   input  logic [2:0]              off,
   input  logic [CONFIG_DW-1:0]    st_data,
   output logic [CONFIG_DW-1:0]    wdat,
   output logic [CONFIG_DW/8-1:0]  wmsk
);

   localparam int NB = CONFIG_DW / 8;

   logic [2:0]    size;
   logic [NB-1:0] size_ones;

   assign size = lsu_pkg::op_size(op);

   // Replicate the low access bytes over every lane
   // Aligned requests then find their data already in place
   always_comb
   begin
      wdat = '0;
      for (int i = 0; i < NB; i++)
      begin
         int src;
         src = i & ((1 << size) - 1);
         wdat[i*8 +: 8] = st_data[src*8 +: 8];
      end
   end

   // One strobe per accessed byte, before the lane shift
   always_comb
   begin
      size_ones = '0;
      for (int i = 0; i < NB; i++)
      begin
         if (i < (1 << size))
            size_ones[i] = 1'b1;
      end
   end

   // Move the strobes up to the addressed lane
   assign wmsk = size_ones << off;

endmodule

//--- src/lsu_unc_fsm.sv
// Uncached access FSM acting as a single-beat AXI4 master
`timescale 1ns/1ps

module lsu_unc_fsm #(
   parameter int CONFIG_AW = 40,
   parameter int CONFIG_DW = 64,
   parameter int AXI_AW    = 32
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     boot,
   input  logic                     stall,
   input  lsu_pkg::lsu_op_e         op,
   input  logic [CONFIG_AW-1:0]     paddr,
   input  logic [CONFIG_DW-1:0]     wdat,
   input  logic [CONFIG_DW/8-1:0]   wmsk,
   output logic                     stall_req,
   output logic                     valid,
   output logic                     err,
   output logic [CONFIG_DW-1:0]     dout,
   output lsu_pkg::lsu_op_e         req_op,
   output logic [2:0]               req_off,
   // Read address
   output logic                     ar_valid,
   input  logic                     ar_ready,
   output logic [AXI_AW-1:0]        ar_addr,
   output logic [2:0]               ar_size,
   output logic [7:0]               ar_len,
   output logic [1:0]               ar_burst,
   output logic [3:0]               ar_cache,
   output logic [2:0]               ar_prot,
   // Read data
   input  logic                     r_valid,
   output logic                     r_ready,
   input  logic [CONFIG_DW-1:0]     r_data,
   input  logic [1:0]               r_resp,
   // Write address
   output logic                     aw_valid,
   input  logic                     aw_ready,
   output logic [AXI_AW-1:0]        aw_addr,
   output logic [2:0]               aw_size,
   output logic [7:0]               aw_len,
   output logic [1:0]               aw_burst,
   output logic [3:0]               aw_cache,
   output logic [2:0]               aw_prot,
   // Write data
   output logic                     w_valid,
   input  logic                     w_ready,
   output logic [CONFIG_DW-1:0]     w_data,
   output logic [CONFIG_DW/8-1:0]   w_strb,
   output logic                     w_last,
   // Write response
   input  logic                     b_valid,
   output logic                     b_ready,
   input  logic [1:0]               b_resp
);

   lsu_pkg::unc_state_e  state_q;
   lsu_pkg::unc_state_e  state_nxt;
   logic                 boot_ok;
   logic                 ar_set;
   logic                 aw_set;
   logic                 r_hs;
   logic                 b_hs;
   logic [AXI_AW-1:0]    arw_addr_nxt;

   // A boot outside IDLE is dropped
   assign boot_ok = boot & (state_q == lsu_pkg::UNC_IDLE);
   assign ar_set  = boot_ok & ~lsu_pkg::op_is_store(op);
   assign aw_set  = boot_ok & lsu_pkg::op_is_store(op);

   assign r_hs = r_valid & r_ready;
   assign b_hs = b_valid & b_ready;

   always_comb
   begin
      state_nxt = state_q;
      case (state_q)
         lsu_pkg::UNC_IDLE:
            if (boot)
               state_nxt = lsu_pkg::op_is_store(op) ? lsu_pkg::UNC_WAIT_B : lsu_pkg::UNC_WAIT_R;
         lsu_pkg::UNC_WAIT_B:
            if (b_hs)
               state_nxt = lsu_pkg::UNC_OUT;
         lsu_pkg::UNC_WAIT_R:
            if (r_hs)
               state_nxt = lsu_pkg::UNC_OUT;
         lsu_pkg::UNC_OUT:
            if (!stall)
               state_nxt = lsu_pkg::UNC_IDLE;
         default:
            state_nxt = lsu_pkg::UNC_IDLE;
      endcase
   end

   // Truncate or zero-fill the physical address to the bus width
   generate
      if (AXI_AW > CONFIG_AW)
      begin : g_addr_fill
         assign arw_addr_nxt = {{(AXI_AW-CONFIG_AW){1'b0}}, paddr};
      end
      else
      begin : g_addr_trunc
         assign arw_addr_nxt = paddr[AXI_AW-1:0];
      end
   endgenerate

   // State, channel valids and error flag
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q  <= lsu_pkg::UNC_IDLE;
         ar_valid <= 1'b0;
         aw_valid <= 1'b0;
         w_valid  <= 1'b0;
         err      <= 1'b0;
      end
      else
      begin
         state_q <= state_nxt;
         if (ar_set)
            ar_valid <= 1'b1;
         else if (ar_ready)
            ar_valid <= 1'b0;
         if (aw_set)
            aw_valid <= 1'b1;
         else if (aw_ready)
            aw_valid <= 1'b0;
         if (aw_set)
            w_valid <= 1'b1;
         else if (w_ready)
            w_valid <= 1'b0;
         // Sticky until the next accepted request
         if (boot_ok)
            err <= 1'b0;
         else if (r_hs)
            err <= (r_resp != lsu_pkg::AXI_RESP_OKAY);
         else if (b_hs)
            err <= (b_resp != lsu_pkg::AXI_RESP_OKAY);
      end
   end

   // Request payload held stable until its handshake
   always_ff @(posedge clk)
   begin
      if (ar_set)
      begin
         ar_addr <= arw_addr_nxt;
         ar_size <= lsu_pkg::op_size(op);
      end
      if (aw_set)
      begin
         aw_addr <= arw_addr_nxt;
         aw_size <= lsu_pkg::op_size(op);
         w_data  <= wdat;
         w_strb  <= wmsk;
      end
      if (boot_ok)
      begin
         req_op  <= op;
         req_off <= paddr[2:0];
      end
      if (r_hs)
         dout <= r_data;
   end

   // Fixed single-beat attributes
   assign ar_len   = 8'd0;
   assign ar_burst = lsu_pkg::AXI_BURST_INCR;
   assign ar_cache = lsu_pkg::AXI_CACHE_NC_NB;
   assign ar_prot  = lsu_pkg::AXI_PROT_DATA_SEC_UNPRIV;
   assign aw_len   = 8'd0;
   assign aw_burst = lsu_pkg::AXI_BURST_INCR;
   assign aw_cache = lsu_pkg::AXI_CACHE_NC_NB;
   assign aw_prot  = lsu_pkg::AXI_PROT_DATA_SEC_UNPRIV;
   assign w_last   = 1'b1;

   assign r_ready = (state_q == lsu_pkg::UNC_WAIT_R);
   assign b_ready = (state_q == lsu_pkg::UNC_WAIT_B);

   // Holds the pipeline from the boot cycle until the response
   assign stall_req = (state_q != lsu_pkg::UNC_OUT) &
                      ((state_q != lsu_pkg::UNC_IDLE) | boot);

   assign valid = (state_q == lsu_pkg::UNC_OUT);

endmodule

//--- src/lsu_load_align.sv
// Load aligner extracting the addressed bytes with sign or zero extension
`timescale 1ns/1ps

module lsu_load_align #(
   parameter int CONFIG_DW = 64
) (
   input  lsu_pkg::lsu_op_e      req_op,
   input  logic [2:0]            req_off,
   input  logic [CONFIG_DW-1:0]  dout,
   output logic [CONFIG_DW-1:0]  rdata
);

   logic [2:0]            size;
   logic [CONFIG_DW-1:0]  shifted;
   logic                  sign_bit;
   logic                  is_store;

   assign size     = lsu_pkg::op_size(req_op);
   assign is_store = lsu_pkg::op_is_store(req_op);

   // Addressed byte lane down to bit 0
   assign shifted = dout >> {req_off, 3'b000};

   // Top bit of the access, only for the signed loads
   always_comb
   begin
      int msb;
      msb = (8 << size) - 1;
      sign_bit = lsu_pkg::op_is_signed(req_op) & shifted[msb];
   end

   always_comb
   begin
      rdata = '0;
      if (!is_store)
      begin
         for (int i = 0; i < CONFIG_DW; i++)
         begin
            // Bits past the access width take the extension
            if (i < (8 << size))
               rdata[i] = shifted[i];
            else
               rdata[i] = sign_bit;
         end
      end
   end

endmodule

//--- src/lsu_unc_top.sv
// Uncached load/store data path with store aligner, AXI access FSM and load aligner
`timescale 1ns/1ps

module lsu_unc_top #(
   parameter int CONFIG_AW = 40,
   parameter int CONFIG_DW = 64,
   parameter int AXI_AW    = 32
) (
   input  logic                     clk,
   input  logic                     rst_n,
   // Pipeline side
   input  logic                     boot,
   input  logic                     stall,
   input  lsu_pkg::lsu_op_e         op,
   input  logic [CONFIG_AW-1:0]     paddr,
   input  logic [CONFIG_DW-1:0]     st_data,
   output logic                     stall_req,
   output logic                     valid,
   output logic [CONFIG_DW-1:0]     rdata,
   output logic                     err,
   // AXI read
   output logic                     ar_valid,
   input  logic                     ar_ready,
   output logic [AXI_AW-1:0]        ar_addr,
   output logic [2:0]               ar_size,
   output logic [7:0]               ar_len,
   output logic [1:0]               ar_burst,
   output logic [3:0]               ar_cache,
   output logic [2:0]               ar_prot,
   input  logic                     r_valid,
   output logic                     r_ready,
   input  logic [CONFIG_DW-1:0]     r_data,
   input  logic [1:0]               r_resp,
   // AXI write
   output logic                     aw_valid,
   input  logic                     aw_ready,
   output logic [AXI_AW-1:0]        aw_addr,
   output logic [2:0]               aw_size,
   output logic [7:0]               aw_len,
   output logic [1:0]               aw_burst,
   output logic [3:0]               aw_cache,
   output logic [2:0]               aw_prot,
   output logic                     w_valid,
   input  logic                     w_ready,
   output logic [CONFIG_DW-1:0]     w_data,
   output logic [CONFIG_DW/8-1:0]   w_strb,
   output logic                     w_last,
   input  logic                     b_valid,
   output logic                     b_ready,
   input  logic [1:0]               b_resp
);

   logic [CONFIG_DW-1:0]    wdat;
   logic [CONFIG_DW/8-1:0]  wmsk;
   logic [CONFIG_DW-1:0]    dout;
   lsu_pkg::lsu_op_e        req_op;
   logic [2:0]              req_off;

   lsu_store_align #(
      .CONFIG_DW (CONFIG_DW)
   ) u_store_align (
      .op      (op),
      .off     (paddr[2:0]),
      .st_data (st_data),
      .wdat    (wdat),
      .wmsk    (wmsk)
   );

   lsu_unc_fsm #(
      .CONFIG_AW (CONFIG_AW),
      .CONFIG_DW (CONFIG_DW),
      .AXI_AW    (AXI_AW)
   ) u_unc_fsm (
      .clk       (clk),
      .rst_n     (rst_n),
      .boot      (boot),
      .stall     (stall),
      .op        (op),
      .paddr     (paddr),
      .wdat      (wdat),
      .wmsk      (wmsk),
      .stall_req (stall_req),
      .valid     (valid),
      .err       (err),
      .dout      (dout),
      .req_op    (req_op),
      .req_off   (req_off),
      .ar_valid  (ar_valid),
      .ar_ready  (ar_ready),
      .ar_addr   (ar_addr),
      .ar_size   (ar_size),
      .ar_len    (ar_len),
      .ar_burst  (ar_burst),
      .ar_cache  (ar_cache),
      .ar_prot   (ar_prot),
      .r_valid   (r_valid),
      .r_ready   (r_ready),
      .r_data    (r_data),
      .r_resp    (r_resp),
      .aw_valid  (aw_valid),
      .aw_ready  (aw_ready),
      .aw_addr   (aw_addr),
      .aw_size   (aw_size),
      .aw_len    (aw_len),
      .aw_burst  (aw_burst),
      .aw_cache  (aw_cache),
      .aw_prot   (aw_prot),
      .w_valid   (w_valid),
      .w_ready   (w_ready),
      .w_data    (w_data),
      .w_strb    (w_strb),
      .w_last    (w_last),
      .b_valid   (b_valid),
      .b_ready   (b_ready),
      .b_resp    (b_resp)
   );

   lsu_load_align #(
      .CONFIG_DW (CONFIG_DW)
   ) u_load_align (
      .req_op  (req_op),
      .req_off (req_off),
      .dout    (dout),
      .rdata   (rdata)
   );

endmodule

//--- sim/tb_axi_mem.sv
// AXI slave memory model with random ready delays, read latency and an error region
`timescale 1ns/1ps

module tb_axi_mem (
   input  logic         clk,
   input  logic         rst_n,
   input  logic         ar_valid,
   output logic         ar_ready,
   input  logic [31:0]  ar_addr,
   output logic         r_valid,
   input  logic         r_ready,
   output logic [63:0]  r_data,
   output logic [1:0]   r_resp,
   input  logic         aw_valid,
   output logic         aw_ready,
   input  logic [31:0]  aw_addr,
   input  logic         w_valid,
   output logic         w_ready,
   input  logic [63:0]  w_data,
   input  logic [7:0]   w_strb,
   output logic         b_valid,
   input  logic         b_ready,
   output logic [1:0]   b_resp
);

   logic [63:0]  mem [0:255];
   logic [31:0]  rd_addr;
   logic [31:0]  wr_addr;
   logic [63:0]  wr_data;
   logic [7:0]   wr_strb;
   logic [3:0]   rd_cnt;
   logic         rd_busy;
   logic         aw_got;
   logic         w_got;

   always_ff @(posedge clk or negedge rst_n)
   begin
      logic [31:0] rnd;
      rnd = $urandom;
      if (!rst_n)
      begin
         ar_ready <= 1'b0;
         aw_ready <= 1'b0;
         w_ready  <= 1'b0;
         r_valid  <= 1'b0;
         b_valid  <= 1'b0;
         r_data   <= '0;
         r_resp   <= 2'b00;
         b_resp   <= 2'b00;
         rd_busy  <= 1'b0;
         aw_got   <= 1'b0;
         w_got    <= 1'b0;
         rd_cnt   <= '0;
         // Fill pattern covering the whole word index
         for (int i = 0; i < 256; i++)
            mem[i] <= {8{i[7:0]}} ^ 64'h0123_4567_89ab_cdef;
      end
      else
      begin
         ar_ready <= !rd_busy && !r_valid && rnd[0];
         aw_ready <= !aw_got && !b_valid && rnd[5];
         w_ready  <= !w_got && !b_valid && rnd[6];
         // Read path, latency of one to eight cycles
         if (ar_valid && ar_ready)
         begin
            rd_busy  <= 1'b1;
            rd_addr  <= ar_addr;
            rd_cnt   <= {1'b0, rnd[3:1]} + 4'd1;
            ar_ready <= 1'b0;
         end
         else if (rd_busy)
         begin
            if (rd_cnt == 4'd1)
            begin
               rd_busy <= 1'b0;
               r_valid <= 1'b1;
               r_resp  <= rd_addr[31] ? 2'b10 : 2'b00;
               r_data  <= rd_addr[31] ? 64'd0 : mem[rd_addr[10:3]];
            end
            else
               rd_cnt <= rd_cnt - 4'd1;
         end
         if (r_valid && r_ready)
            r_valid <= 1'b0;
         // Write path, address and data in any order
         if (aw_valid && aw_ready)
         begin
            aw_got   <= 1'b1;
            wr_addr  <= aw_addr;
            aw_ready <= 1'b0;
         end
         if (w_valid && w_ready)
         begin
            w_got   <= 1'b1;
            wr_data <= w_data;
            wr_strb <= w_strb;
            w_ready <= 1'b0;
         end
         if (aw_got && w_got && !b_valid)
         begin
            aw_got  <= 1'b0;
            w_got   <= 1'b0;
            b_valid <= 1'b1;
            b_resp  <= wr_addr[31] ? 2'b10 : 2'b00;
            // Error region drops the write
            if (!wr_addr[31])
            begin
               for (int b = 0; b < 8; b++)
               begin
                  if (wr_strb[b])
                     mem[wr_addr[10:3]][b*8 +: 8] <= wr_data[b*8 +: 8];
               end
            end
         end
         if (b_valid && b_ready)
            b_valid <= 1'b0;
      end
   end

endmodule

//--- sim/tb_lsu_unc.sv
// Testbench for the uncached LSU path with reference model, shadow memory and compare tasks
`timescale 1ns/1ps

module tb_lsu_unc;

   logic              clk;
   logic              rst_n;
   logic              boot;
   logic              stall;
   lsu_pkg::lsu_op_e  op;
   logic [39:0]       paddr;
   logic [63:0]       st_data;
   logic              stall_req;
   logic              valid;
   logic [63:0]       rdata;
   logic              err;
   logic              ar_valid;
   logic              ar_ready;
   logic              r_valid;
   logic              r_ready;
   logic              aw_valid;
   logic              aw_ready;
   logic              w_valid;
   logic              w_ready;
   logic              b_valid;
   logic              b_ready;
   logic [31:0]       ar_addr;
   logic [31:0]       aw_addr;
   logic [2:0]        ar_size;
   logic [2:0]        aw_size;
   logic [7:0]        ar_len;
   logic [7:0]        aw_len;
   logic [1:0]        ar_burst;
   logic [1:0]        aw_burst;
   logic [3:0]        ar_cache;
   logic [3:0]        aw_cache;
   logic [2:0]        ar_prot;
   logic [2:0]        aw_prot;
   logic              w_last;
   logic [63:0]       r_data;
   logic [63:0]       w_data;
   logic [7:0]        w_strb;
   logic [1:0]        r_resp;
   logic [1:0]        b_resp;

   logic [63:0]       shadow [0:255];
   int                n_tests;
   int                n_bad_tests;
   int                n_errors;
   logic              test_bad;
   logic              timed_out;

   lsu_unc_top #(
      .CONFIG_AW (40),
      .CONFIG_DW (64),
      .AXI_AW    (32)
   ) u_dut (
      .clk (clk), .rst_n (rst_n), .boot (boot), .stall (stall), .op (op),
      .paddr (paddr), .st_data (st_data), .stall_req (stall_req), .valid (valid),
      .rdata (rdata), .err (err),
      .ar_valid (ar_valid), .ar_ready (ar_ready), .ar_addr (ar_addr), .ar_size (ar_size),
      .ar_len (ar_len), .ar_burst (ar_burst), .ar_cache (ar_cache), .ar_prot (ar_prot),
      .r_valid (r_valid), .r_ready (r_ready), .r_data (r_data), .r_resp (r_resp),
      .aw_valid (aw_valid), .aw_ready (aw_ready), .aw_addr (aw_addr), .aw_size (aw_size),
      .aw_len (aw_len), .aw_burst (aw_burst), .aw_cache (aw_cache), .aw_prot (aw_prot),
      .w_valid (w_valid), .w_ready (w_ready), .w_data (w_data), .w_strb (w_strb),
      .w_last (w_last), .b_valid (b_valid), .b_ready (b_ready), .b_resp (b_resp)
   );

   tb_axi_mem u_mem (
      .clk (clk), .rst_n (rst_n),
      .ar_valid (ar_valid), .ar_ready (ar_ready), .ar_addr (ar_addr),
      .r_valid (r_valid), .r_ready (r_ready), .r_data (r_data), .r_resp (r_resp),
      .aw_valid (aw_valid), .aw_ready (aw_ready), .aw_addr (aw_addr),
      .w_valid (w_valid), .w_ready (w_ready), .w_data (w_data), .w_strb (w_strb),
      .b_valid (b_valid), .b_ready (b_ready), .b_resp (b_resp)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic int access_bytes(lsu_pkg::lsu_op_e o);
      case (o)
         lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: return 1;
         lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
         lsu_pkg::LW, lsu_pkg::LWU, lsu_pkg::SW: return 4;
         default: return 8;
      endcase
   endfunction

   function automatic lsu_pkg::lsu_op_e store_op_of(int sz);
      case (sz)
         0: return lsu_pkg::SB;
         1: return lsu_pkg::SH;
         2: return lsu_pkg::SW;
         default: return lsu_pkg::SD;
      endcase
   endfunction

   function automatic lsu_pkg::lsu_op_e load_op_of(int n);
      case (n)
         0: return lsu_pkg::LB;
         1: return lsu_pkg::LH;
         2: return lsu_pkg::LW;
         3: return lsu_pkg::LBU;
         4: return lsu_pkg::LHU;
         5: return lsu_pkg::LWU;
         default: return lsu_pkg::LD;
      endcase
   endfunction

   // Expected load result from the shadow memory
   function automatic logic [63:0] ref_load(lsu_pkg::lsu_op_e o, logic [39:0] a);
      logic [63:0] sh;
      logic [63:0] res;
      logic        sgn;
      int          nbits;
      bit          is_load;
      is_load = (o == lsu_pkg::LB) || (o == lsu_pkg::LH) || (o == lsu_pkg::LW) ||
                (o == lsu_pkg::LD) || (o == lsu_pkg::LBU) || (o == lsu_pkg::LHU) ||
                (o == lsu_pkg::LWU);
      if (!is_load || a[31])
         return 64'd0;
      sh = shadow[a[10:3]] >> (8 * a[2:0]);
      nbits = 8 * access_bytes(o);
      sgn = ((o == lsu_pkg::LB) || (o == lsu_pkg::LH) || (o == lsu_pkg::LW)) && sh[nbits-1];
      for (int i = 0; i < 64; i++)
         res[i] = (i < nbits) ? sh[i] : sgn;
      return res;
   endfunction

   task automatic check_data(string name, logic [63:0] exp, logic [63:0] act);
      if (exp !== act)
      begin
         $display("MISMATCH %s expected %h actual %h", name, exp, act);
         n_errors++;
         test_bad = 1'b1;
      end
   endtask

   task automatic check_err(string name, logic exp, logic act);
      if (exp !== act)
      begin
         $display("MISMATCH %s expected %b actual %b", name, exp, act);
         n_errors++;
         test_bad = 1'b1;
      end
   endtask

   // One access, optionally held in OUT by stall for hold cycles
   task automatic run_test(string name, lsu_pkg::lsu_op_e o, logic [39:0] a,
                           logic [63:0] d, int hold);
      logic [63:0] exp_data;
      logic [63:0] held_data;
      logic        exp_err;
      logic        held_err;
      logic        is_st;
      logic [2:0]  exp_size;
      logic [19:0] exp_attr;
      int          cnt;
      if (timed_out)
         return;
      is_st = (o == lsu_pkg::SB) || (o == lsu_pkg::SH) || (o == lsu_pkg::SW) ||
              (o == lsu_pkg::SD);
      exp_data = ref_load(o, a);
      exp_err = a[31];
      exp_size = 3'($clog2(access_bytes(o)));
      // Single-beat INCR request with normal non-cacheable secure data attributes
      exp_attr = {exp_size, 8'd0, 2'b01, 4'b0010, 3'b000};
      test_bad = 1'b0;
      @(posedge clk);
      boot <= 1'b1;
      op <= o;
      paddr <= a;
      st_data <= d;
      stall <= (hold > 0);
      @(negedge clk);
      check_err({name, " stall_req in boot cycle"}, 1'b1, stall_req);
      @(posedge clk);
      boot <= 1'b0;
      @(negedge clk);
      check_err({name, " request raised"}, 1'b1, is_st ? (aw_valid & w_valid) : ar_valid);
      if (is_st)
      begin
         check_data({name, " aw_addr"}, {32'd0, a[31:0]}, {32'd0, aw_addr});
         check_data({name, " aw attributes"}, {44'd0, exp_attr},
                    {44'd0, aw_size, aw_len, aw_burst, aw_cache, aw_prot});
         check_err({name, " w_last"}, 1'b1, w_last);
      end
      else
      begin
         check_data({name, " ar_addr"}, {32'd0, a[31:0]}, {32'd0, ar_addr});
         check_data({name, " ar attributes"}, {44'd0, exp_attr},
                    {44'd0, ar_size, ar_len, ar_burst, ar_cache, ar_prot});
      end
      cnt = 0;
      while (!valid && !timed_out)
      begin
         check_err({name, " stall_req while waiting"}, 1'b1, stall_req);
         @(negedge clk);
         cnt++;
         if (cnt > 100)
         begin
            $display("Timeout: valid never rose in %s", name);
            timed_out = 1'b1;
         end
      end
      if (timed_out)
         return;
      check_data(name, exp_data, rdata);
      check_err({name, " err"}, exp_err, err);
      check_err({name, " stall_req released"}, 1'b0, stall_req);
      held_data = rdata;
      held_err = err;
      for (int k = 0; k < hold; k++)
      begin
         @(posedge clk);
         // A boot while the result waits must be dropped
         boot <= (k == 0);
         op <= lsu_pkg::LD;
         @(negedge clk);
         check_err({name, " valid held"}, 1'b1, valid);
         check_data({name, " rdata held"}, held_data, rdata);
         check_err({name, " err held"}, held_err, err);
         check_err({name, " no new request"}, 1'b0, ar_valid | aw_valid);
      end
      if (hold > 0)
      begin
         @(posedge clk);
         boot <= 1'b0;
         stall <= 1'b0;
      end
      if (is_st && !a[31])
      begin
         for (int b = 0; b < access_bytes(o); b++)
            shadow[a[10:3]][(int'(a[2:0]) + b)*8 +: 8] = d[b*8 +: 8];
      end
      n_tests++;
      if (test_bad)
         n_bad_tests++;
      $display("%s %s", test_bad ? "fail" : "pass", name);
   endtask

   initial
   begin
      logic [7:0]  idx;
      logic [2:0]  off;
      int          nb;
      int          hold;
      lsu_pkg::lsu_op_e lop;
      void'($urandom(32'h0425_cfb1));
      rst_n = 1'b0;
      boot = 1'b0;
      stall = 1'b0;
      op = lsu_pkg::LD;
      paddr = '0;
      st_data = '0;
      n_tests = 0;
      n_bad_tests = 0;
      n_errors = 0;
      timed_out = 1'b0;
      test_bad = 1'b0;
      for (int i = 0; i < 256; i++)
         shadow[i] = {8{i[7:0]}} ^ 64'h0123_4567_89ab_cdef;
      repeat (10) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);

      // Reset state
      check_err("reset valid", 1'b0, valid);
      check_err("reset stall_req", 1'b0, stall_req);
      check_err("reset err", 1'b0, err);
      check_err("reset axi valids and readies", 1'b0,
                ar_valid | aw_valid | w_valid | r_ready | b_ready);
      n_tests++;
      if (test_bad)
         n_bad_tests++;
      $display("%s reset state", test_bad ? "fail" : "pass");

      // Round trip for every size and aligned offset
      for (int sz = 0; sz < 4; sz++)
      begin
         for (int o = 0; o < 8; o += (1 << sz))
         begin
            idx = 8'($urandom);
            run_test($sformatf("store sz%0d off%0d", sz, o), store_op_of(sz),
                     {29'd0, idx, 3'(o)}, {$urandom, $urandom}, 0);
            run_test($sformatf("readback sz%0d off%0d", sz, o), lsu_pkg::LD,
                     {29'd0, idx, 3'd0}, 64'd0, 0);
         end
      end

      // Sign and zero extension on random data
      for (int n = 0; n < 24; n++)
      begin
         idx = 8'($urandom);
         lop = load_op_of(n % 7);
         nb = access_bytes(lop);
         off = 3'($urandom) & ~3'(nb - 1);
         run_test($sformatf("ext fill %0d", n), lsu_pkg::SD, {29'd0, idx, 3'd0},
                  {$urandom, $urandom}, 0);
         run_test($sformatf("ext %s off%0d", lop.name(), off), lop, {29'd0, idx, off},
                  64'd0, 0);
      end

      // Back-pressure with a dropped boot
      for (int n = 0; n < 6; n++)
      begin
         idx = 8'($urandom);
         hold = 2 + int'($urandom % 5);
         lop = (n % 2 == 0) ? lsu_pkg::LD : lsu_pkg::SW;
         off = (n % 2 == 0) ? 3'd0 : 3'd4;
         run_test($sformatf("stall %0d hold %0d", n, hold), lop, {29'd0, idx, off},
                  {$urandom, $urandom}, hold);
      end

      // Error region and err clearing
      idx = 8'h3c;
      run_test("err store", lsu_pkg::SD, {8'd0, 1'b1, 20'd0, idx, 3'd0},
               64'hdead_beef_dead_beef, 0);
      run_test("after err store", lsu_pkg::LD, {29'd0, idx, 3'd0}, 64'd0, 0);
      run_test("err load", lsu_pkg::LW, {8'd0, 1'b1, 20'd3, idx, 3'd4}, 64'd0, 2);
      run_test("after err load", lsu_pkg::LHU, {29'd0, idx, 3'd2}, 64'd0, 0);

      // Upper address bits dropped on the bus
      idx = 8'ha7;
      run_test("alias store", lsu_pkg::SD, {8'hc3, 1'b0, 20'h5a5a5, idx, 3'd0},
               {$urandom, $urandom}, 0);
      run_test("alias plain", lsu_pkg::LD, {29'd0, idx, 3'd0}, 64'd0, 0);
      run_test("alias other", lsu_pkg::LD, {8'h3c, 1'b0, 20'h00001, idx, 3'd0}, 64'd0, 0);

      $display("tests %0d, failed tests %0d, errors %0d, timeout %0d",
               n_tests, n_bad_tests, n_errors, timed_out);
      if (n_errors == 0 && n_bad_tests == 0 && !timed_out)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

//--- all.f
src/lsu_pkg.sv
src/lsu_store_align.sv
src/lsu_unc_fsm.sv
src/lsu_load_align.sv
src/lsu_unc_top.sv
sim/tb_axi_mem.sv
sim/tb_lsu_unc.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     = --binary --timing
TOP       = tb_lsu_unc
FLIST     = all.f

SRCS = $(shell grep -v '^+' $(FLIST))
BIN  = obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) | grep -F "Test OK"

clean:
	rm -rf obj_dir
